//--- list.f
+incdir+rtl
+incdir+sim
rtl/heapPkg.sv
rtl/heapTable.sv
rtl/elementStore.sv
rtl/elementAlu.sv
rtl/heapTop.sv
sim/heapTb.sv

//--- rtl/elementAlu.sv
// Execute stage. Computes the element result, writes it back combinationally
// and registers the response. Failed requests write nothing and return zero
`timescale 1ns/100ps
`default_nettype none

module elementAlu (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    fetValid,
  input  wire heapPkg::heapOpT   fetOp,
  input  wire heapPkg::elemAddrT fetAddr,
  input  wire heapPkg::dataT     fetOperand,
  input  wire heapPkg::dataT     fetInfo,
  input  wire heapPkg::heapErrT  fetErr,
  input  wire heapPkg::dataT     fetData,
  output logic                   wrEnable,
  output heapPkg::elemAddrT      wrAddr,
  output heapPkg::dataT          wrData,
  output logic                   done,
  output heapPkg::dataT          dataOut,
  output heapPkg::heapErrT       error
);
  import heapPkg::*;

  dataT aluResult;                          // Value to store
  dataT respData;                           // Value to return
  logic storesElem;

  // ------------------------------
  always_comb begin
    case (fetOp)
      opAdd:   aluResult = fetData + fetOperand; // Wraps at data width
      opSub:   aluResult = fetData - fetOperand;
      opAnd:   aluResult = fetData & fetOperand;
      opOr:    aluResult = fetData | fetOperand;
      opXor:   aluResult = fetData ^ fetOperand;
      default: aluResult = fetOperand;      // Write and push store dataIn
    endcase
    storesElem = fetOp inside {opWrite, opPush, opAdd, opSub, opAnd, opOr, opXor};
    if (fetErr != errNone) begin
      respData = '0;
    end else begin
      case (fetOp)
        opRead, opPop:  respData = fetData;
        opAlloc, opSize: respData = fetInfo;  // Array number or size
        opClear, opFree: respData = '0;
        default:        respData = aluResult;
      endcase
    end
  end

  assign wrEnable = fetValid && (fetErr == errNone) && storesElem;
  assign wrAddr   = fetAddr;
  assign wrData   = aluResult;

  // Response register
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      done <= fetValid;                     // One pulse per request
      if (fetValid) begin
        dataOut <= respData;
        error   <= fetErr;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/elementStore.sv
// Fetch stage with the element memory, one write port and one registered read
// A write landing on the read address in the same cycle is forwarded
// Element memory has no reset
`timescale 1ns/100ps
`default_nettype none

module elementStore (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    chkValid,
  input  wire heapPkg::heapOpT   chkOp,
  input  wire heapPkg::elemAddrT chkAddr,
  input  wire heapPkg::dataT     chkOperand,
  input  wire heapPkg::dataT     chkInfo,
  input  wire heapPkg::heapErrT  chkErr,
  input  wire                    wrEnable,
  input  wire heapPkg::elemAddrT wrAddr,
  input  wire heapPkg::dataT     wrData,
  output logic                   fetValid,
  output heapPkg::heapOpT        fetOp,
  output heapPkg::elemAddrT      fetAddr,
  output heapPkg::dataT          fetOperand,
  output heapPkg::dataT          fetInfo,
  output heapPkg::heapErrT       fetErr,
  output heapPkg::dataT          fetData
);
  import heapPkg::*;

  localparam int numElems = 1 << $bits(elemAddrT);

  dataT mem [numElems];                     // All arrays, fixed blocks
  logic bypass;                             // Write hits this read

  assign bypass = wrEnable && (wrAddr == chkAddr);

  // ------------------------------
  always_ff @(posedge clock) begin
    if (wrEnable) mem[wrAddr] <= wrData;    // Execute-stage write back
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      fetValid <= 1'b0;
    end else begin
      fetValid <= chkValid;
    end
  end

  // Stage payload
  always_ff @(posedge clock) begin
    fetOp      <= chkOp;
    fetAddr    <= chkAddr;
    fetOperand <= chkOperand;
    fetInfo    <= chkInfo;
    fetErr     <= chkErr;
    fetData    <= bypass ? wrData : mem[chkAddr]; // Newest value of the element
  end

endmodule

`default_nettype wire

//--- rtl/heapPkg.sv
// Shared types for the array heap
// Widths come from heap_cfg.svh. Op and error encodings follow enum order
`default_nettype none

package heapPkg;

`include "heap_cfg.svh"

  // ------------------------------
  // Widths with a meaning
  typedef logic [`HEAP_ARRAY_BITS-1:0]                  arrayIdT;  // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]                  elemIdxT;  // Element index
  typedef logic [`HEAP_INDEX_BITS:0]                    sizeT;     // 0 to array length
  typedef logic [`HEAP_DATA_BITS-1:0]                   dataT;     // Element value
  typedef logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] elemAddrT; // Array then index

  // ------------------------------
  // Request operations
  typedef enum logic [3:0] {
    opClear,  // Free all arrays
    opAlloc,  // New array, returns its number
    opFree,   // Return array to free stack
    opWrite,  // Store element, grow size
    opRead,   // Fetch element
    opSize,   // Current size
    opPush,   // Store at size, grow by one
    opPop,    // Shrink by one, return top
    opAdd,    // Element arithmetic, new value returned
    opSub,
    opAnd,
    opOr,
    opXor
  } heapOpT;

  // Response error codes
  typedef enum logic [2:0] {
    errNone,
    errNotAllocated, // Never allocated or freed
    errOutOfBounds,  // Index not below size
    errFull,         // Push to full array
    errEmpty,        // Pop from empty array
    errNoMemory      // Alloc with nothing left
  } heapErrT;

endpackage

`default_nettype wire

//--- rtl/heapTable.sv
// Check stage. Requests are registered on entry, checked in the next cycle,
// and bookkeeping commits on the same edge as the chk outputs
// Only error-free requests change allocation flags, free stack or sizes
`timescale 1ns/100ps
`default_nettype none

module heapTable (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    start,
  input  wire heapPkg::heapOpT   op,
  input  wire heapPkg::arrayIdT  arrayId,
  input  wire heapPkg::elemIdxT  index,
  input  wire heapPkg::dataT     dataIn,
  output logic                   chkValid,
  output heapPkg::heapOpT        chkOp,
  output heapPkg::elemAddrT      chkAddr,
  output heapPkg::dataT          chkOperand,
  output heapPkg::dataT          chkInfo,
  output heapPkg::heapErrT       chkErr
);
  import heapPkg::*;

  localparam int numArrays   = 1 << $bits(arrayIdT);
  localparam int arrayLength = 1 << $bits(elemIdxT);

  typedef logic [$bits(arrayIdT):0] countT; // 0 to numArrays

  // ------------------------------
  // Entry register
  logic    reqValid;
  heapOpT  reqOp;
  arrayIdT reqArray;
  elemIdxT reqIndex;
  dataT    reqData;

  // Bookkeeping
  logic    allocated [numArrays];           // Live arrays
  arrayIdT freeStack [numArrays];           // Freed arrays, most recent on top
  countT   freeTop;                         // Entries on free stack
  countT   allocCount;                      // Arrays ever handed out fresh
  sizeT    sizes     [numArrays];

  // Check results
  sizeT    curSize;
  sizeT    writeSize;
  logic    isAlloc;
  countT   topBelow;
  arrayIdT allocId;
  elemIdxT resolvedIdx;
  heapErrT checkErr;
  logic    commit;

  // ------------------------------
  always_comb begin
    curSize     = sizes[reqArray];
    isAlloc     = allocated[reqArray];
    topBelow    = freeTop - 1'b1;
    writeSize   = sizeT'(reqIndex) + 1'b1;
    allocId     = (freeTop != '0) ? freeStack[arrayIdT'(topBelow)] : arrayIdT'(allocCount);
    resolvedIdx = reqIndex;                 // Most ops address by index
    checkErr    = errNone;
    case (reqOp)
      opClear: checkErr = errNone;
      opAlloc: begin
        if (freeTop == '0 && allocCount == countT'(numArrays)) checkErr = errNoMemory;
      end
      opFree, opWrite, opSize: begin
        if (!isAlloc) checkErr = errNotAllocated;
      end
      opPush: begin
        resolvedIdx = elemIdxT'(curSize);   // Slot just past the top
        if (!isAlloc) checkErr = errNotAllocated;
        else if (curSize == sizeT'(arrayLength)) checkErr = errFull;
      end
      opPop: begin
        resolvedIdx = elemIdxT'(curSize - 1'b1); // Current top element
        if (!isAlloc) checkErr = errNotAllocated;
        else if (curSize == '0) checkErr = errEmpty;
      end
      default: begin                        // Read and element arithmetic
        if (!isAlloc) checkErr = errNotAllocated;
        else if (sizeT'(reqIndex) >= curSize) checkErr = errOutOfBounds;
      end
    endcase
  end

  assign commit = reqValid && (checkErr == errNone);

  // ------------------------------
  // Control state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      reqValid   <= 1'b0;
      chkValid   <= 1'b0;
      freeTop    <= '0;
      allocCount <= '0;
      for (int i = 0; i < numArrays; i++) begin
        allocated[i] <= 1'b0;
        sizes[i]     <= '0;
      end
    end else begin
      reqValid <= start;
      chkValid <= reqValid;
      if (commit) begin
        case (reqOp)
          opClear: begin                    // Back to reset state
            freeTop    <= '0;
            allocCount <= '0;
            for (int i = 0; i < numArrays; i++) begin
              allocated[i] <= 1'b0;
              sizes[i]     <= '0;
            end
          end
          opAlloc: begin
            if (freeTop != '0) freeTop <= topBelow; // Reuse latest freed
            else allocCount <= allocCount + 1'b1;
            allocated[allocId] <= 1'b1;
            sizes[allocId]     <= '0;
          end
          opFree: begin
            allocated[reqArray] <= 1'b0;    // Blocks a second free
            freeTop             <= freeTop + 1'b1;
          end
          opWrite: if (writeSize > curSize) sizes[reqArray] <= writeSize;
          opPush:  sizes[reqArray] <= curSize + 1'b1;
          opPop:   sizes[reqArray] <= curSize - 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Payload and free stack storage
  always_ff @(posedge clock) begin
    reqOp      <= op;
    reqArray   <= arrayId;
    reqIndex   <= index;
    reqData    <= dataIn;
    chkOp      <= reqOp;
    chkAddr    <= {reqArray, resolvedIdx};
    chkOperand <= reqData;
    chkInfo    <= (reqOp == opAlloc) ? dataT'(allocId) : dataT'(curSize);
    chkErr     <= checkErr;
    if (commit && reqOp == opFree) freeStack[arrayIdT'(freeTop)] <= reqArray;
  end

endmodule

`default_nettype wire

//--- rtl/heapTop.sv
// Pipelined array heap, one request per cycle, no back-pressure
// Response arrives three edges after the request is sampled, in order
`timescale 1ns/100ps
`default_nettype none

module heapTop (
  input  wire                   clock,
  input  wire                   resetN,
  input  wire                   start,
  input  wire heapPkg::heapOpT  op,
  input  wire heapPkg::arrayIdT arrayId,
  input  wire heapPkg::elemIdxT index,
  input  wire heapPkg::dataT    dataIn,
  output logic                  done,
  output heapPkg::dataT         dataOut,
  output heapPkg::heapErrT      error
);
  import heapPkg::*;

  // ------------------------------
  // Check to fetch
  logic     chkValid;
  heapOpT   chkOp;
  elemAddrT chkAddr;
  dataT     chkOperand;
  dataT     chkInfo;
  heapErrT  chkErr;

  // Fetch to execute
  logic     fetValid;
  heapOpT   fetOp;
  elemAddrT fetAddr;
  dataT     fetOperand;
  dataT     fetInfo;
  heapErrT  fetErr;
  dataT     fetData;

  // Write back
  logic     wrEnable;
  elemAddrT wrAddr;
  dataT     wrData;

  heapTable uTable (
    .clock      (clock),
    .resetN     (resetN),
    .start      (start),
    .op         (op),
    .arrayId    (arrayId),
    .index      (index),
    .dataIn     (dataIn),
    .chkValid   (chkValid),
    .chkOp      (chkOp),
    .chkAddr    (chkAddr),
    .chkOperand (chkOperand),
    .chkInfo    (chkInfo),
    .chkErr     (chkErr)
  );

  elementStore uStore (
    .clock      (clock),
    .resetN     (resetN),
    .chkValid   (chkValid),
    .chkOp      (chkOp),
    .chkAddr    (chkAddr),
    .chkOperand (chkOperand),
    .chkInfo    (chkInfo),
    .chkErr     (chkErr),
    .wrEnable   (wrEnable),
    .wrAddr     (wrAddr),
    .wrData     (wrData),
    .fetValid   (fetValid),
    .fetOp      (fetOp),
    .fetAddr    (fetAddr),
    .fetOperand (fetOperand),
    .fetInfo    (fetInfo),
    .fetErr     (fetErr),
    .fetData    (fetData)
  );

  elementAlu uAlu (
    .clock      (clock),
    .resetN     (resetN),
    .fetValid   (fetValid),
    .fetOp      (fetOp),
    .fetAddr    (fetAddr),
    .fetOperand (fetOperand),
    .fetInfo    (fetInfo),
    .fetErr     (fetErr),
    .fetData    (fetData),
    .wrEnable   (wrEnable),
    .wrAddr     (wrAddr),
    .wrData     (wrData),
    .done       (done),
    .dataOut    (dataOut),
    .error      (error)
  );

endmodule

`default_nettype wire

//--- rtl/heap_cfg.svh
// Width settings for the array heap
// Array count and array length are powers of two derived from these bits
// HEAP_DATA_BITS must be at least HEAP_INDEX_BITS + 1 so a size fits in an element
`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

`define HEAP_ARRAY_BITS 2  // 4 arrays
`define HEAP_INDEX_BITS 2  // 4 elements per array
`define HEAP_DATA_BITS  12 // Element width

`endif

//--- sim/heapTests.svh
// Directed tests, included inside the heapTb module body
// Expected responses come from the reference model in heapTb
`ifndef HEAP_TESTS_SVH
`define HEAP_TESTS_SVH

  // ------------------------------
  task automatic allocationTest();
    currentTest = "allocation";
    sendAndWait(opSize, 2, 0, '0);        // Nothing allocated out of reset
    sendAndWait(opAlloc, 0, 0, '0);       // First fresh array after reset
    sendAndWait(opClear, 0, 0, '0);
    for (int i = 0; i <= numArrays; i++) begin
      sendAndWait(opAlloc, 0, 0, '0);     // Last one finds no array left
    end
    sendAndWait(opFree, 2, 0, '0);
    sendAndWait(opFree, 1, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);       // Latest freed comes back first
    sendAndWait(opAlloc, 0, 0, '0);
    sendAndWait(opFree, 3, 0, '0);
    sendAndWait(opFree, 3, 0, '0);        // Double free
    sendAndWait(opAlloc, 0, 0, '0);
    sendAndWait(opClear, 0, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);       // Numbering restarts at 0
  endtask

  task automatic accessTest();
    dataT first;
    dataT second;
    currentTest = "write read size";
    first       = randomData();
    second      = randomData();
    sendAndWait(opClear, 0, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);
    sendAndWait(opWrite, 0, 0, first);
    sendAndWait(opWrite, 0, 2, second);
    sendAndWait(opSize, 0, 0, '0);        // Highest index plus one
    sendAndWait(opRead, 0, 0, '0);
    sendAndWait(opRead, 0, 2, '0);
    sendAndWait(opRead, 0, 3, '0);        // Past the size
    sendAndWait(opWrite, 0, 0, second);   // Overwrite keeps size
    sendAndWait(opSize, 0, 0, '0);
    sendAndWait(opRead, 0, 0, '0);
    // Array 1 was never allocated
    sendAndWait(opWrite, 1, 0, first);
    sendAndWait(opRead, 1, 0, '0);
    sendAndWait(opSize, 1, 0, '0);
    sendAndWait(opPush, 1, 0, first);
    sendAndWait(opPop, 1, 0, '0);
    sendAndWait(opXor, 1, 0, first);
    sendAndWait(opFree, 1, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);       // Failed requests left array 1 empty
    sendAndWait(opSize, 1, 0, '0);
  endtask

  task automatic stackTest();
    currentTest = "push pop";
    sendAndWait(opClear, 0, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);
    for (int i = 0; i < arrayLength; i++) begin
      sendAndWait(opPush, 0, 0, randomData());
    end
    sendAndWait(opPush, 0, 0, randomData()); // Full
    sendAndWait(opSize, 0, 0, '0);
    for (int i = 0; i < arrayLength; i++) begin
      sendAndWait(opPop, 0, 0, '0);       // Newest first
    end
    sendAndWait(opPop, 0, 0, '0);         // Empty
    sendAndWait(opSize, 0, 0, '0);
  endtask

  task automatic arithmeticTest();
    currentTest = "arithmetic";
    sendAndWait(opClear, 0, 0, '0);
    sendAndWait(opAlloc, 0, 0, '0);
    for (int i = 0; i < arrayLength; i++) begin
      sendAndWait(opWrite, 0, i, randomData());
      sendAndWait(opAdd, 0, i, randomData());
      sendAndWait(opSub, 0, i, randomData());
      sendAndWait(opAnd, 0, i, randomData());
      sendAndWait(opOr, 0, i, randomData());
      sendAndWait(opXor, 0, i, randomData());
      sendAndWait(opRead, 0, i, '0);      // Stored result stays
    end
    sendAndWait(opWrite, 0, 0, '1);       // Wrap at the data width
    sendAndWait(opAdd, 0, 0, dataT'(1));
    sendAndWait(opSub, 0, 0, dataT'(1));
    sendAndWait(opAlloc, 0, 0, '0);
    sendAndWait(opAdd, 1, 0, randomData()); // Nothing readable yet
  endtask

  // ------------------------------
  task automatic sendPaced(input bit spaced, input heapOpT reqOp, input int arr,
                           input int idx, input dataT value);
    if (spaced) sendAndWait(reqOp, arr, idx, value);
    else sendRequest(reqOp, arr, idx, value);
  endtask

  task automatic mixedSequence(input bit spaced, input dataT valueA, input dataT valueB);
    sendPaced(spaced, opClear, 0, 0, '0);
    sendPaced(spaced, opAlloc, 0, 0, '0);
    sendPaced(spaced, opWrite, 0, 0, valueA);
    sendPaced(spaced, opAdd, 0, 0, valueB); // Same element several times running
    sendPaced(spaced, opAdd, 0, 0, valueB);
    sendPaced(spaced, opSub, 0, 0, valueA);
    sendPaced(spaced, opXor, 0, 0, valueB);
    sendPaced(spaced, opRead, 0, 0, '0);
    sendPaced(spaced, opPush, 0, 0, valueB); // Pop right behind the push
    sendPaced(spaced, opPop, 0, 0, '0);
    sendPaced(spaced, opPush, 0, 0, valueA);
    sendPaced(spaced, opPush, 0, 0, valueB);
    sendPaced(spaced, opPop, 0, 0, '0);
    sendPaced(spaced, opSize, 0, 0, '0);
    sendPaced(spaced, opWrite, 0, 3, valueA);
    sendPaced(spaced, opRead, 0, 3, '0);
    sendPaced(spaced, opAlloc, 0, 0, '0);
    sendPaced(spaced, opWrite, 1, 1, valueB);
    sendPaced(spaced, opRead, 1, 1, '0);
    sendPaced(spaced, opFree, 1, 0, '0);
    sendPaced(spaced, opFree, 1, 0, '0);  // Must see the first free
    sendPaced(spaced, opAlloc, 0, 0, '0);
    waitIdle();
  endtask

  task automatic backToBackTest();
    dataT valueA;
    dataT valueB;
    valueA      = randomData();
    valueB      = randomData();
    currentTest = "spaced sequence";
    mixedSequence(1'b1, valueA, valueB);
    currentTest = "back to back";
    mixedSequence(1'b0, valueA, valueB);
  endtask

`endif

//--- sim/heapTb.sv
// Testbench for heapTop with a sequential reference model of the heap
// Inputs change on the falling edge and outputs are sampled on the falling edge
// Stops at the first wrong, missing or unexpected response
`timescale 1ns/100ps
`default_nettype none

module heapTb;
  import heapPkg::*;

  localparam int clockPeriod   = 10;
  localparam int resetCycles   = 3;
  localparam int latency       = 4;   // Drive edge to done, in falling edges
  localparam int requestBudget = 160; // Above the request count of all tests
  localparam int cyclesPerReq  = 6;   // Spaced request plus pipeline drain
  localparam int numArrays     = 1 << $bits(arrayIdT);
  localparam int arrayLength   = 1 << $bits(elemIdxT);

  // DUT ports
  logic        clock;
  logic        resetN;
  logic        start;
  heapOpT      op;
  arrayIdT     arrayId;
  elemIdxT     index;
  dataT        dataIn;
  logic        done;
  dataT        dataOut;
  heapErrT     error;

  int          cycleCount;                // Rising edges so far
  string       currentTest;

  // ------------------------------
  // Expected responses, oldest first
  dataT        expData [$];
  heapErrT     expErr  [$];
  int          expDue  [$];               // Cycle count when done is due
  string       expName [$];

  // Reference model state
  logic        modelAlloc [numArrays];
  int          modelSize  [numArrays];
  int          modelFree  [$];            // Freed arrays, latest at back
  int          modelFresh;                // Arrays never handed out start here
  dataT        modelMem   [numArrays*arrayLength];

  heapTop DUT (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .op      (op),
    .arrayId (arrayId),
    .index   (index),
    .dataIn  (dataIn),
    .done    (done),
    .dataOut (dataOut),
    .error   (error)
  );

  initial clock = 1'b0;
  always #(clockPeriod / 2) clock = ~clock;

  always @(posedge clock) cycleCount <= cycleCount + 1;

  // ------------------------------
  task automatic stopOnError();
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic checkValue(input string name, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s: expected %0h, actual %0h", name, what, expected, actual);
      stopOnError();
    end
  endtask

  // Response monitor
  always @(negedge clock) begin
    if (done) begin
      if (expDue.size() == 0) begin
        $display("Unexpected done pulse at cycle %0d with no request in flight", cycleCount);
        stopOnError();
      end else if (expDue[0] != cycleCount) begin
        $display("done pulse at cycle %0d in test %s, expected at cycle %0d",
                 cycleCount, expName[0], expDue[0]);
        stopOnError();
      end else begin
        checkValue(expName[0], "dataOut", 32'(expData[0]), 32'(dataOut));
        checkValue(expName[0], "error", 32'(expErr[0]), 32'(error));
        void'(expData.pop_front());
        void'(expErr.pop_front());
        void'(expDue.pop_front());
        void'(expName.pop_front());
      end
    end else if (expDue.size() != 0 && expDue[0] == cycleCount) begin
      $display("Missing done pulse at cycle %0d in test %s", cycleCount, expName[0]);
      stopOnError();
    end
  end

  // Watchdog
  initial begin
    #((resetCycles + requestBudget * cyclesPerReq + 50) * clockPeriod);
    $display("Timeout: tests did not finish in the time allowed for all requests");
    stopOnError();
  end

  // ------------------------------
  // Reference model
  task automatic resetModel();
    for (int i = 0; i < numArrays; i++) begin
      modelAlloc[i] = 1'b0;
      modelSize[i]  = 0;
    end
    modelFree.delete();
    modelFresh = 0;
  endtask

  task automatic predictResponse(input heapOpT reqOp, input int arr, input int idx,
                                 input dataT value, output dataT result,
                                 output heapErrT err);
    int   addr;
    int   picked;
    dataT elem;
    addr   = arr * arrayLength + idx;
    result = '0;
    err    = errNone;
    picked = -1;
    if (reqOp == opClear) begin
      resetModel();
    end else if (reqOp == opAlloc) begin
      if (modelFree.size() != 0) begin
        picked = modelFree.pop_back();    // Latest freed first
      end else if (modelFresh < numArrays) begin
        picked     = modelFresh;
        modelFresh = modelFresh + 1;
      end
      if (picked < 0) begin
        err = errNoMemory;
      end else begin
        modelAlloc[picked] = 1'b1;
        modelSize[picked]  = 0;
        result             = dataT'(picked);
      end
    end else if (!modelAlloc[arr]) begin
      err = errNotAllocated;
    end else begin
      case (reqOp)
        opFree: begin
          modelAlloc[arr] = 1'b0;
          modelFree.push_back(arr);
        end
        opWrite: begin
          modelMem[addr] = value;
          if (idx + 1 > modelSize[arr]) modelSize[arr] = idx + 1;
          result = value;
        end
        opSize: result = dataT'(modelSize[arr]);
        opPush: begin
          if (modelSize[arr] == arrayLength) begin
            err = errFull;
          end else begin
            modelMem[arr * arrayLength + modelSize[arr]] = value;
            modelSize[arr] = modelSize[arr] + 1;
            result         = value;
          end
        end
        opPop: begin
          if (modelSize[arr] == 0) begin
            err = errEmpty;
          end else begin
            modelSize[arr] = modelSize[arr] - 1;
            result         = modelMem[arr * arrayLength + modelSize[arr]];
          end
        end
        default: begin                    // Read and element arithmetic
          elem = modelMem[addr];
          if (idx >= modelSize[arr]) begin
            err = errOutOfBounds;
          end else if (reqOp == opRead) begin
            result = elem;
          end else begin
            case (reqOp)
              opAdd:   result = elem + value; // Keeps the low data bits
              opSub:   result = elem - value;
              opAnd:   result = elem & value;
              opOr:    result = elem | value;
              default: result = elem ^ value;
            endcase
            modelMem[addr] = result;
          end
        end
      endcase
    end
  endtask

  // ------------------------------
  // Request driving, called on a falling edge
  task automatic sendRequest(input heapOpT reqOp, input int arr, input int idx,
                             input dataT value);
    dataT    predData;
    heapErrT predErr;
    predictResponse(reqOp, arr, idx, value, predData, predErr);
    expData.push_back(predData);
    expErr.push_back(predErr);
    expDue.push_back(cycleCount + latency);
    expName.push_back(currentTest);
    start   = 1'b1;
    op      = reqOp;
    arrayId = arrayIdT'(arr);
    index   = elemIdxT'(idx);
    dataIn  = value;
    @(negedge clock);
    start   = 1'b0;
  endtask

  task automatic waitIdle();
    while (expDue.size() != 0) @(negedge clock); // Until every response is checked
  endtask

  task automatic sendAndWait(input heapOpT reqOp, input int arr, input int idx,
                             input dataT value);
    sendRequest(reqOp, arr, idx, value);
    waitIdle();
  endtask

  function automatic dataT randomData();
    return dataT'($urandom);
  endfunction

`include "heapTests.svh"

  // ------------------------------
  initial begin
    void'($urandom(57568));
    cycleCount  = 0;
    currentTest = "reset";
    resetN      = 1'b0;
    start       = 1'b0;
    op          = opClear;
    arrayId     = '0;
    index       = '0;
    dataIn      = '0;
    resetModel();
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;
    checkValue("reset", "done", 32'(1'b0), 32'(done));
    checkValue("reset", "dataOut", 32'(0), 32'(dataOut));
    checkValue("reset", "error", 32'(errNone), 32'(error));
    allocationTest();
    accessTest();
    stackTest();
    arithmeticTest();
    backToBackTest();
    waitIdle();
    repeat (latency) @(negedge clock);    // Room for a stray done pulse
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
